// ==== hdl/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

	// byte address as seen by fetch and memory.
	typedef logic [31:0] addr_t;

	// line geometry.
	localparam int LINE_BYTES = 32;
	localparam int OFFSET_BITS = $clog2(LINE_BYTES);
	localparam int BEATS_PER_LINE = 4;

	// one memory beat, two instruction words.
	typedef logic [63:0] beat_t;

	// a stored instruction word together with its predecode result.
	typedef struct packed {
		logic [31:0] instr;
		logic        branch;
		logic        call;
		logic        ret;
		addr_t       target;
	} word_entry_t;

	// one slot of a fetch group.
	typedef struct packed {
		logic        valid;
		word_entry_t entry;
	} fetch_slot_t;

	// opcodes that predecode looks at.
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;

endpackage

`default_nettype wire

// ==== hdl/refill_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface refill_if
	import icache_pkg::*;
#(
	parameter int INDEX_BITS = 4
);
	// one accepted refill beat.
	logic                  wen;
	logic [INDEX_BITS-1:0] index;
	logic [1:0]            beat;
	beat_t                 data;
	// line base, needed for branch targets.
	addr_t                 line_addr;

	modport ctrl (output wen, index, beat, data, line_addr);
	modport array (input wen, index, beat, data, line_addr);

endinterface

`default_nettype wire

// ==== hdl/sram_sp.sv ====
`timescale 1ns/1ns
`default_nettype none

module sram_sp #(
	parameter int DEPTH_BITS = 4,
	parameter type payload_t = logic [31:0]
) (
	input  logic                  clk,
	input  logic [DEPTH_BITS-1:0] addr,
	input  logic                  wen,
	input  payload_t              wdata,
	output payload_t              rdata
);

	payload_t mem [2**DEPTH_BITS];

	// write on the clock edge.
	always_ff @(posedge clk) begin
		if (wen) begin
			mem[addr] <= wdata;
		end
	end

	// read is combinational, same cycle as the address.
	assign rdata = mem[addr];

endmodule

`default_nettype wire

// ==== hdl/predecode.sv ====
`timescale 1ns/1ns
`default_nettype none

module predecode
	import icache_pkg::*;
(
	input  logic [31:0] instr,
	input  addr_t       pc,
	output logic        branch,
	output logic        call,
	output logic        ret,
	output addr_t       target
);

	logic [6:0] opcode;
	logic [4:0] rd;
	logic [4:0] rs1;
	addr_t      imm_b;
	addr_t      imm_j;
	logic       is_jal;
	logic       is_jalr;

	assign opcode = instr[6:0];
	assign rd = instr[11:7];
	assign rs1 = instr[19:15];

	assign is_jal = (opcode == OPC_JAL);
	assign is_jalr = (opcode == OPC_JALR);

	// sign-extended immediates, bit 0 always zero.
	assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	assign branch = (opcode == OPC_BRANCH);
	// a jump that links counts as a call.
	assign call = (is_jal || is_jalr) && (rd != 5'd0);
	assign ret = is_jalr && (rs1 == 5'd1);

	always_comb begin
		if (branch) begin
			target = pc + imm_b;
		end else if (is_jal) begin
			target = pc + imm_j;
		end else begin
			// jalr target is register based, fall through.
			target = pc + 32'd4;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/icache_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_ctrl
	import icache_pkg::*;
#(
	parameter int INDEX_BITS = 4
) (
	input  logic   clk,
	input  logic   reset,
	input  logic   fetch_valid,
	input  addr_t  fetch_addr,
	output logic   fetch_ready,
	output logic   mem_req_valid,
	output addr_t  mem_req_addr,
	input  logic   mem_req_ready,
	input  logic   mem_resp_valid,
	input  beat_t  mem_resp_data,
	input  logic   mem_resp_last,
	refill_if.ctrl refill
);

	localparam int TAG_BITS = $bits(addr_t) - OFFSET_BITS - INDEX_BITS;

	typedef struct packed {
		logic                valid;
		logic [TAG_BITS-1:0] tag;
	} meta_t;

	typedef enum logic [1:0] {
		IDLE,
		REQ,
		RECV
	} state_t;

	state_t                              state;
	state_t                              state_nxt;
	logic [$clog2(BEATS_PER_LINE)-1:0]   beat_cnt;
	logic [2**INDEX_BITS-1:0]            valid_q;
	addr_t                               miss_addr;

	logic [INDEX_BITS-1:0] fetch_index;
	logic [TAG_BITS-1:0]   fetch_tag;
	logic [INDEX_BITS-1:0] miss_index;
	logic [TAG_BITS-1:0]   miss_tag;
	logic [INDEX_BITS-1:0] meta_addr;
	meta_t                 meta_rd;
	meta_t                 meta_wr;
	logic                  meta_wen;
	logic                  beat_wen;
	logic                  hit;

	assign fetch_index = fetch_addr[OFFSET_BITS +: INDEX_BITS];
	assign fetch_tag = fetch_addr[$bits(addr_t)-1 -: TAG_BITS];
	assign miss_index = miss_addr[OFFSET_BITS +: INDEX_BITS];
	assign miss_tag = miss_addr[$bits(addr_t)-1 -: TAG_BITS];

	// tag ram follows the fill line while receiving.
	assign meta_addr = (state == RECV) ? miss_index : fetch_index;
	assign meta_wr = '{valid: 1'b1, tag: miss_tag};

	sram_sp #(
		.DEPTH_BITS(INDEX_BITS),
		.payload_t (meta_t)
	) u_meta (
		.clk  (clk),
		.addr (meta_addr),
		.wen  (meta_wen),
		.wdata(meta_wr),
		.rdata(meta_rd)
	);

	assign hit = valid_q[fetch_index] && meta_rd.valid && (meta_rd.tag == fetch_tag);

	assign beat_wen = (state == RECV) && mem_resp_valid;
	// line becomes valid together with its last beat.
	assign meta_wen = beat_wen && mem_resp_last;

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (fetch_valid && !hit) begin
					state_nxt = REQ;
				end
			end
			REQ: begin
				if (mem_req_ready) begin
					state_nxt = RECV;
				end
			end
			RECV: begin
				if (meta_wen) begin
					state_nxt = IDLE;
				end
			end
			default: begin
				state_nxt = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			beat_cnt <= '0;
			valid_q <= '0;
		end else begin
			state <= state_nxt;
			if (state == REQ) begin
				beat_cnt <= '0;
			end else if (beat_wen) begin
				beat_cnt <= beat_cnt + 1'b1;
			end
			if (meta_wen) begin
				valid_q[miss_index] <= 1'b1;
			end
		end
	end

	// capture the missing address so the request stays stable.
	always_ff @(posedge clk) begin
		if (state == IDLE && fetch_valid && !hit) begin
			miss_addr <= fetch_addr;
		end
	end

	assign fetch_ready = (state == IDLE) && fetch_valid && hit;
	assign mem_req_valid = (state == REQ);
	assign mem_req_addr = {miss_addr[$bits(addr_t)-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

	assign refill.wen = beat_wen;
	assign refill.index = miss_index;
	assign refill.beat = beat_cnt;
	assign refill.data = mem_resp_data;
	assign refill.line_addr = mem_req_addr;

endmodule

`default_nettype wire

// ==== hdl/icache_data.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_data
	import icache_pkg::*;
#(
	parameter int INDEX_BITS = 4
) (
	input  logic              clk,
	input  addr_t             fetch_addr,
	refill_if.array           refill,
	output fetch_slot_t [3:0] fetch_slots
);

	// index plus the group bit selects a word row in every bank.
	logic [INDEX_BITS:0] bank_addr;
	logic [3:0]          bank_wen;
	word_entry_t [3:0]   bank_rd;
	word_entry_t [1:0]   wr_entry;

	always_comb begin
		if (refill.wen) begin
			bank_addr = {refill.index, refill.beat[1]};
		end else begin
			bank_addr = {fetch_addr[OFFSET_BITS +: INDEX_BITS], fetch_addr[4]};
		end
	end

	// predecode the low and the high word of the incoming beat.
	for (genvar h = 0; h < 2; h++) begin : g_pd
		localparam logic HALF = 1'(h);

		logic [31:0] word;
		addr_t       word_pc;

		assign word = refill.data[32*h +: 32];
		assign word_pc = refill.line_addr + addr_t'({refill.beat, HALF, 2'b00});
		assign wr_entry[h].instr = word;

		predecode u_predecode (
			.instr (word),
			.pc    (word_pc),
			.branch(wr_entry[h].branch),
			.call  (wr_entry[h].call),
			.ret   (wr_entry[h].ret),
			.target(wr_entry[h].target)
		);
	end

	// bank b holds group position b.
	for (genvar b = 0; b < 4; b++) begin : g_bank
		localparam logic [1:0] POS = 2'(b);

		// even beats fill positions 0 and 1, odd beats 2 and 3.
		assign bank_wen[b] = refill.wen && (refill.beat[0] == POS[1]);

		sram_sp #(
			.DEPTH_BITS(INDEX_BITS + 1),
			.payload_t (word_entry_t)
		) u_bank (
			.clk  (clk),
			.addr (bank_addr),
			.wen  (bank_wen[b]),
			.wdata(wr_entry[POS[0]]),
			.rdata(bank_rd[b])
		);
	end

	// rotate so slot 0 is the addressed word.
	for (genvar i = 0; i < 4; i++) begin : g_slot
		localparam logic [1:0] SLOT = 2'(i);

		logic [1:0] sel;

		assign sel = fetch_addr[3:2] + SLOT;
		assign fetch_slots[i].entry = bank_rd[sel];
		// slots past the end of the group are not valid.
		assign fetch_slots[i].valid = ({1'b0, fetch_addr[3:2]} + {1'b0, SLOT}) <= 3'd3;
	end

endmodule

`default_nettype wire

// ==== hdl/icache_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_top
	import icache_pkg::*;
#(
	parameter int INDEX_BITS = 4
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              fetch_valid,
	input  addr_t             fetch_addr,
	output logic              fetch_ready,
	output fetch_slot_t [3:0] fetch_slots,
	output logic              mem_req_valid,
	output addr_t             mem_req_addr,
	input  logic              mem_req_ready,
	input  logic              mem_resp_valid,
	input  beat_t             mem_resp_data,
	input  logic              mem_resp_last
);

	// refill beats from controller to data array.
	refill_if #(
		.INDEX_BITS(INDEX_BITS)
	) u_refill ();

	icache_ctrl #(
		.INDEX_BITS(INDEX_BITS)
	) u_ctrl (
		.clk           (clk),
		.reset         (reset),
		.fetch_valid   (fetch_valid),
		.fetch_addr    (fetch_addr),
		.fetch_ready   (fetch_ready),
		.mem_req_valid (mem_req_valid),
		.mem_req_addr  (mem_req_addr),
		.mem_req_ready (mem_req_ready),
		.mem_resp_valid(mem_resp_valid),
		.mem_resp_data (mem_resp_data),
		.mem_resp_last (mem_resp_last),
		.refill        (u_refill.ctrl)
	);

	icache_data #(
		.INDEX_BITS(INDEX_BITS)
	) u_data (
		.clk        (clk),
		.fetch_addr (fetch_addr),
		.refill     (u_refill.array),
		.fetch_slots(fetch_slots)
	);

endmodule

`default_nettype wire

// ==== testbench/icache_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_assert
	import icache_pkg::*;
(
	input logic  clk,
	input logic  reset,
	input logic  fetch_ready,
	input logic  mem_req_valid,
	input addr_t mem_req_addr,
	input logic  mem_req_ready
);

	// a pending request keeps its address until memory takes it.
	req_stable: assert property (@(posedge clk) disable iff (reset)
		mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr))
	else $error("memory request dropped or changed before it was accepted");

	// hits are served only from idle.
	no_overlap: assert property (@(posedge clk) disable iff (reset)
		!(fetch_ready && mem_req_valid))
	else $error("fetch_ready and mem_req_valid were high together");

	req_low_after_reset: assert property (@(posedge clk) reset |=> !mem_req_valid)
	else $error("mem_req_valid was high in the cycle after reset");

endmodule

bind icache_top icache_assert u_assert (
	.clk          (clk),
	.reset        (reset),
	.fetch_ready  (fetch_ready),
	.mem_req_valid(mem_req_valid),
	.mem_req_addr (mem_req_addr),
	.mem_req_ready(mem_req_ready)
);

`default_nettype wire

// ==== testbench/icache_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_tb
	import icache_pkg::*;
();

	localparam int INDEX_BITS = 4;
	// about 20 misses of at most 30 cycles plus 40 hits fit well inside this.
	localparam int TIMEOUT_CYCLES = 2000;

	logic              clk;
	logic              reset;
	logic              fetch_valid;
	addr_t             fetch_addr;
	logic              fetch_ready;
	fetch_slot_t [3:0] fetch_slots;
	logic              mem_req_valid;
	addr_t             mem_req_addr;
	logic              mem_req_ready;
	logic              mem_resp_valid;
	beat_t             mem_resp_data;
	logic              mem_resp_last;

	logic [31:0]       mem_words [1024];
	// expected cache contents as one line number per index.
	logic [26:0]       shadow_line [16];
	logic [15:0]       shadow_valid;
	fetch_slot_t [3:0] last_slots;
	int                req_count;
	addr_t             last_req_addr;
	int                delay_max;
	int                cycle_count = 0;

	icache_top #(
		.INDEX_BITS(INDEX_BITS)
	) u_dut (
		.clk           (clk),
		.reset         (reset),
		.fetch_valid   (fetch_valid),
		.fetch_addr    (fetch_addr),
		.fetch_ready   (fetch_ready),
		.fetch_slots   (fetch_slots),
		.mem_req_valid (mem_req_valid),
		.mem_req_addr  (mem_req_addr),
		.mem_req_ready (mem_req_ready),
		.mem_resp_valid(mem_resp_valid),
		.mem_resp_data (mem_resp_data),
		.mem_resp_last (mem_resp_last)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("RESULT: FAIL");
			$fatal(1, "timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		end
	end

	task automatic report_mismatch(string name, logic [67:0] got, logic [67:0] exp);
		$display("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp);
		$display("RESULT: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic abort_with_message(string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic idle_cycles(int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic load_memory();
		void'($urandom(32'hc0ca));
		for (int i = 0; i < 1024; i++) begin
			mem_words[i] = $urandom;
		end
		// line 0x100 holds one word of each predecode case.
		mem_words[64] = 32'h00208863; // beq x1, x2, +16
		mem_words[65] = 32'h020000ef; // jal x1, +32
		mem_words[66] = 32'hffdff06f; // jal x0, -4
		mem_words[67] = 32'h00008067; // jalr x0, 0(x1)
		mem_words[68] = 32'h000280e7; // jalr x1, 0(x5)
		mem_words[69] = 32'h000080e7; // jalr x1, 0(x1)
		mem_words[70] = 32'h00000013; // addi x0, x0, 0
	endtask

	// memory model with a random wait before ready and between beats.
	task automatic serve_request();
		addr_t      base;
		logic [9:0] w0;
		base = mem_req_addr;
		idle_cycles(1 + $urandom % (delay_max + 1));
		mem_req_ready = 1'b1;
		idle_cycles(1);
		mem_req_ready = 1'b0;
		req_count++;
		last_req_addr = base;
		for (int k = 0; k < BEATS_PER_LINE; k++) begin
			idle_cycles($urandom % (delay_max + 1));
			w0 = base[11:2] + 10'(2 * k);
			mem_resp_valid = 1'b1;
			mem_resp_data = {mem_words[w0 + 10'd1], mem_words[w0]};
			mem_resp_last = (k == BEATS_PER_LINE - 1);
			idle_cycles(1);
			mem_resp_valid = 1'b0;
			mem_resp_last = 1'b0;
		end
	endtask

	initial begin
		wait (reset == 1'b0);
		forever begin
			@(negedge clk);
			if (mem_req_valid) begin
				serve_request();
			end
		end
	end

	// reference decode of one stored word.
	function automatic word_entry_t expected_entry(addr_t pc);
		logic [31:0] w;
		int          off;
		word_entry_t e;
		w = mem_words[pc[11:2]];
		e.instr = w;
		e.branch = (w[6:0] == OPC_BRANCH);
		e.call = (w[6:0] == OPC_JAL || w[6:0] == OPC_JALR) && (w[11:7] != 5'd0);
		e.ret = (w[6:0] == OPC_JALR) && (w[19:15] == 5'd1);
		off = 4;
		if (e.branch) begin
			off = (w[31] ? -4096 : 0) + (int'(w[7]) << 11) + (int'(w[30:25]) << 5)
				+ (int'(w[11:8]) << 1);
		end else if (w[6:0] == OPC_JAL) begin
			off = (w[31] ? -1048576 : 0) + (int'(w[19:12]) << 12) + (int'(w[20]) << 11)
				+ (int'(w[30:21]) << 1);
		end
		e.target = pc + addr_t'(off);
		return e;
	endfunction

	task automatic check_slots(addr_t addr);
		int          pos;
		word_entry_t exp;
		for (int i = 0; i < 4; i++) begin
			pos = int'(addr[3:2]) + i;
			assert (last_slots[i].valid == (pos <= 3))
			else report_mismatch($sformatf("fetch_slots[%0d].valid", i),
				68'(last_slots[i].valid), 68'(pos <= 3));
			if (pos <= 3) begin
				exp = expected_entry({addr[31:4], 4'h0} + addr_t'(4 * pos));
				assert (last_slots[i].entry == exp)
				else report_mismatch($sformatf("fetch_slots[%0d].entry", i),
					68'(last_slots[i].entry), 68'(exp));
			end
		end
	endtask

	// one fetch checked for hit or miss, request count and slot contents.
	task automatic fetch_and_check(addr_t addr);
		logic [3:0] idx;
		logic       hit_exp;
		int         reqs_before;
		int         waited;
		idx = addr[8:5];
		hit_exp = shadow_valid[idx] && (shadow_line[idx] == addr[31:5]);
		reqs_before = req_count;
		waited = 0;
		fetch_valid = 1'b1;
		fetch_addr = addr;
		@(negedge clk);
		while (!fetch_ready) begin
			@(negedge clk);
			waited++;
		end
		last_slots = fetch_slots;
		assert ((waited == 0) == hit_exp)
		else abort_with_message($sformatf("fetch of 0x%08h should have been a %s",
			addr, hit_exp ? "hit" : "miss"));
		assert (req_count == reqs_before + (hit_exp ? 0 : 1))
		else report_mismatch("req_count", 68'(req_count),
			68'(reqs_before + (hit_exp ? 0 : 1)));
		if (!hit_exp) begin
			assert (last_req_addr == {addr[31:5], 5'b0})
			else report_mismatch("mem_req_addr", 68'(last_req_addr), 68'({addr[31:5], 5'b0}));
			shadow_valid[idx] = 1'b1;
			shadow_line[idx] = addr[31:5];
		end
		check_slots(addr);
		@(posedge clk);
		#1;
		fetch_valid = 1'b0;
	endtask

	task automatic miss_then_hits();
		// a cold miss followed by hits in both groups of its line.
		fetch_and_check(32'h044);
		fetch_and_check(32'h048);
		fetch_and_check(32'h040);
		fetch_and_check(32'h05c);
		fetch_and_check(32'h050);
	endtask

	task automatic word_offsets();
		for (int i = 0; i < 8; i++) begin
			fetch_and_check(32'h0a0 + addr_t'(4 * i));
		end
	endtask

	task automatic predecode_cases();
		// hand-decoded {branch, call, ret} and target of each known word.
		logic [2:0] flags [7] = '{3'b100, 3'b010, 3'b000, 3'b001, 3'b010, 3'b011, 3'b000};
		addr_t targets [7] = '{32'h110, 32'h124, 32'h104, 32'h110, 32'h114, 32'h118, 32'h11c};
		for (int i = 0; i < 7; i++) begin
			fetch_and_check(32'h100 + addr_t'(4 * i));
			assert ({last_slots[0].entry.branch, last_slots[0].entry.call,
				last_slots[0].entry.ret} == flags[i])
			else report_mismatch("fetch_slots[0].entry.{branch,call,ret}",
				68'({last_slots[0].entry.branch, last_slots[0].entry.call,
				last_slots[0].entry.ret}), 68'(flags[i]));
			assert (last_slots[0].entry.target == targets[i])
			else report_mismatch("fetch_slots[0].entry.target", 68'(last_slots[0].entry.target),
				68'(targets[i]));
		end
	endtask

	task automatic tag_eviction();
		// 0x244 shares index 2 with 0x44.
		fetch_and_check(32'h244);
		fetch_and_check(32'h04c);
		fetch_and_check(32'h04c);
	endtask

	task automatic memory_delays();
		addr_t addr;
		for (int i = 0; i < 4; i++) begin
			addr = {20'h0, 12'($urandom) & 12'hffc};
			delay_max = 0;
			fetch_and_check(addr);
			fetch_and_check(addr ^ 32'h200);
			delay_max = 3;
			fetch_and_check(addr);
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		fetch_valid = 1'b0;
		fetch_addr = '0;
		mem_req_ready = 1'b0;
		mem_resp_valid = 1'b0;
		mem_resp_data = '0;
		mem_resp_last = 1'b0;
		shadow_valid = '0;
		req_count = 0;
		last_req_addr = '0;
		delay_max = 3;
		load_memory();
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;
		miss_then_hits();
		word_offsets();
		predecode_cases();
		tag_eviction();
		memory_delays();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== icache_top.f ====
hdl/icache_pkg.sv
hdl/refill_if.sv
hdl/sram_sp.sv
hdl/predecode.sv
hdl/icache_ctrl.sv
hdl/icache_data.sv
hdl/icache_top.sv
testbench/icache_assert.sv
testbench/icache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the icache testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module icache_tb -f icache_top.f -o icache_sim \
	|| { echo "build failed"; exit 1; }

out=$(./obj_dir/icache_sim)
echo "$out"

echo "$out" | grep -qx "RESULT: PASS" && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
